// ==== uno_pkg.sv ====
/*
 * uno deck shared definitions
 * card encoding, deck constants, draw codes and the ordered-deck lookup
 */
package uno_pkg;

    typedef logic [5:0] card_t;    // [5:4] colour, [3:0] value
    typedef logic [6:0] idx_t;     // deck position or fill count

    localparam int DECK_SIZE       = 108;
    localparam int CARDS_PER_COLOR = 27;
    localparam int INSERT_MIX_MIN  = 20;   // discard count where mixing starts

    localparam logic [2:0] DRAW_ONE  = 3'b001;
    localparam logic [2:0] DRAW_TWO  = 3'b010;
    localparam logic [2:0] DRAW_FOUR = 3'b100;

    localparam logic [3:0] VAL_SKIP       = 4'd10;  // then reverse, draw two
    localparam logic [3:0] VAL_WILD       = 4'd13;
    localparam logic [3:0] VAL_WILD_DRAW4 = 4'd14;

    // card at a given position of the factory-ordered deck
    // each colour block: 0, 1..9 twice, skip/reverse/draw two twice, wild, wild draw four
    function automatic card_t ordered_card(input idx_t pos);
        int         color;
        int         offset;
        logic [3:0] value;
        color  = int'(pos) / CARDS_PER_COLOR;
        offset = int'(pos) % CARDS_PER_COLOR;
        if (offset == 0) begin
            value = 4'd0;
        end else if (offset <= 18) begin
            value = 4'((offset + 1) / 2);                // number pairs
        end else if (offset <= 24) begin
            value = VAL_SKIP + 4'((offset - 19) / 2);    // action pairs
        end else if (offset == 25) begin
            value = VAL_WILD;
        end else begin
            value = VAL_WILD_DRAW4;
        end
        return {2'(color), value};
    endfunction

endpackage

// ==== card_lfsr.sv ====
/*
 * card_lfsr
 * free-running seed counter plus a 7-bit LFSR giving random deck indices
 */
`timescale 1ns/1ps

module card_lfsr import uno_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    output idx_t o_rand_idx
);

    idx_t seed_cnt;
    idx_t lfsr;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            seed_cnt <= '0;
            lfsr     <= 7'd1;                      // nonzero so inserts mix before a start
        end else begin
            seed_cnt <= seed_cnt + 1'b1;           // free running
            if (i_start) begin
                lfsr <= (seed_cnt == '0) ? 7'd1 : seed_cnt;   // zero would lock the lfsr
            end else begin
                lfsr <= {lfsr[3] ^ lfsr[0], lfsr[6:1]};
            end
        end
    end

    assign o_rand_idx = lfsr;

endmodule

// ==== card_bank.sv ====
/*
 * card_bank
 * one 108-entry card store with a fill count. The top card sits at count-1.
 * Supports load, clear, swap, push, mixed push and pop, one per cycle.
 */
`timescale 1ns/1ps

module card_bank import uno_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_load_full,
    input  logic  i_clear,
    input  logic  i_swap,
    input  logic  i_push,
    input  logic  i_push_mix,
    input  logic  i_pop,
    input  idx_t  i_cursor,
    input  idx_t  i_rand_idx,
    input  card_t i_card,
    output card_t o_top_card,
    output idx_t  o_count
);

    card_t mem [DECK_SIZE];
    idx_t  count;
    idx_t  top_idx;

    assign top_idx    = (count == '0) ? '0 : count - 1'b1;   // keep index in range when empty
    assign o_top_card = mem[top_idx];
    assign o_count    = count;

    // fill count
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;
        end else if (i_load_full) begin
            count <= idx_t'(DECK_SIZE);
        end else if (i_clear) begin
            count <= '0;
        end else if (i_push || i_push_mix) begin
            count <= count + 1'b1;
        end else if (i_pop) begin
            count <= count - 1'b1;
        end
    end

    // card store
    always_ff @(posedge i_clk) begin
        if (i_load_full) begin
            for (int i = 0; i < DECK_SIZE; i++) begin
                mem[i] <= ordered_card(idx_t'(i));
            end
        end else if (i_swap) begin
            mem[i_cursor]   <= mem[i_rand_idx];
            mem[i_rand_idx] <= mem[i_cursor];
        end else if (i_push) begin
            mem[count] <= i_card;                   // straight on top
        end else if (i_push_mix) begin
            mem[count]      <= mem[i_rand_idx];     // displaced card goes on top
            mem[i_rand_idx] <= i_card;              // wins when rand_idx == count
        end
    end

    // the controller must track both piles so these never happen
    a_no_pop_empty : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> count != '0
    );

    a_no_push_full : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_push || i_push_mix) |-> count != idx_t'(DECK_SIZE)
    );

endmodule

// ==== deck_ctrl.sv ====
/*
 * deck_ctrl
 * deck FSM: init, shuffle, insert, draw and the pile swap.
 * draw_sel names the bank acting as draw pile, the other one is the discard pile.
 */
`timescale 1ns/1ps

module deck_ctrl import uno_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_insert,
    input  logic [2:0] i_draw,
    input  idx_t       i_rand_idx,
    input  idx_t       i_count_0,
    input  idx_t       i_count_1,
    output logic       o_load_full_0,
    output logic       o_clear_0,
    output logic       o_swap_0,
    output logic       o_push_0,
    output logic       o_push_mix_0,
    output logic       o_pop_0,
    output logic       o_load_full_1,
    output logic       o_clear_1,
    output logic       o_swap_1,
    output logic       o_push_1,
    output logic       o_push_mix_1,
    output logic       o_pop_1,
    output idx_t       o_cursor,
    output logic       o_draw_sel,
    output logic       o_done,
    output logic       o_drawn
);

    typedef enum logic [2:0] {
        S_INIT,
        S_IDLE,
        S_SHUFFLE,
        S_INSERT,
        S_DRAW,
        S_WAIT,
        S_SWAP
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic [2:0] draw_cnt;       // code value equals card count
    idx_t       cursor;
    logic       draw_sel;
    idx_t       draw_count;
    idx_t       disc_count;
    logic       cursor_hit;
    logic       count_hit;
    logic       op_load;
    logic       op_clear;
    logic       op_swap;
    logic       op_push;
    logic       op_push_mix;
    logic       op_pop;

    assign draw_count = draw_sel ? i_count_1 : i_count_0;
    assign disc_count = draw_sel ? i_count_0 : i_count_1;
    assign cursor_hit = (i_rand_idx <= cursor);       // usable swap partner
    assign count_hit  = (i_rand_idx <= disc_count);   // usable mix slot

    always_comb begin
        state_nxt   = state;
        op_load     = 1'b0;
        op_clear    = 1'b0;
        op_swap     = 1'b0;
        op_push     = 1'b0;
        op_push_mix = 1'b0;
        op_pop      = 1'b0;
        o_drawn     = 1'b0;
        case (state)
            S_INIT: begin
                op_load   = 1'b1;
                state_nxt = S_IDLE;
            end
            S_IDLE: begin
                if (i_start) begin
                    if (draw_count > 7'd1) state_nxt = S_SHUFFLE;
                end else if (i_insert) begin
                    if (disc_count < idx_t'(DECK_SIZE)) state_nxt = S_INSERT;   // full pile drops it
                end else if (|i_draw) begin
                    state_nxt = S_DRAW;
                end
            end
            S_SHUFFLE: begin
                if (cursor_hit) begin
                    op_swap = 1'b1;
                    if (cursor == 7'd1) state_nxt = S_IDLE;
                end                                      // else retry next lfsr value
            end
            S_INSERT: begin
                if (disc_count < idx_t'(INSERT_MIX_MIN)) begin
                    op_push   = 1'b1;
                    state_nxt = S_IDLE;
                end else if (count_hit) begin
                    op_push_mix = 1'b1;
                    state_nxt   = S_IDLE;
                end
            end
            S_DRAW: begin
                if (draw_count != '0) begin
                    o_drawn   = 1'b1;
                    state_nxt = S_WAIT;
                end else if (disc_count != '0) begin
                    state_nxt = S_SWAP;                  // recycle discards first
                end else begin
                    state_nxt = S_IDLE;                  // nothing left, drop the rest
                end
            end
            S_WAIT: begin
                op_pop = 1'b1;
                if (draw_count == 7'd1 && disc_count != '0) begin
                    state_nxt = S_SWAP;
                end else if (draw_cnt == 3'd1) begin
                    state_nxt = S_IDLE;
                end else begin
                    state_nxt = S_DRAW;
                end
            end
            S_SWAP: begin
                op_clear  = 1'b1;                        // emptied bank becomes discard
                state_nxt = (draw_cnt != '0) ? S_DRAW : S_IDLE;
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= S_INIT;
            draw_cnt <= '0;
            cursor   <= '0;
            draw_sel <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == S_IDLE) begin
                draw_cnt <= i_draw;
                cursor   <= draw_count - 1'b1;           // top of draw pile
            end else begin
                if (op_pop) draw_cnt <= draw_cnt - 1'b1;
                if (op_swap) cursor <= cursor - 1'b1;
            end
            if (op_clear) draw_sel <= ~draw_sel;
        end
    end

    // draw-pile ops go to draw_sel, discard ops to the other bank
    assign o_load_full_0 = op_load & ~draw_sel;
    assign o_load_full_1 = op_load & draw_sel;
    assign o_clear_0     = op_clear & ~draw_sel;
    assign o_clear_1     = op_clear & draw_sel;
    assign o_swap_0      = op_swap & ~draw_sel;
    assign o_swap_1      = op_swap & draw_sel;
    assign o_pop_0       = op_pop & ~draw_sel;
    assign o_pop_1       = op_pop & draw_sel;
    assign o_push_0      = op_push & draw_sel;
    assign o_push_1      = op_push & ~draw_sel;
    assign o_push_mix_0  = op_push_mix & draw_sel;
    assign o_push_mix_1  = op_push_mix & ~draw_sel;

    assign o_cursor   = cursor;
    assign o_draw_sel = draw_sel;
    assign o_done     = (state == S_IDLE);

    // a drawn card comes off a nonempty draw pile, its count one lower two cycles on
    a_drawn_pops : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_drawn |-> ##2 (int'(draw_count) == int'($past(draw_count, 2)) - 1)
    );

    a_draw_onehot : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_done |-> $onehot0(i_draw)
    );

endmodule

// ==== uno_deck.sv ====
/*
 * uno_deck
 * top level of the card deck: LFSR, two identical card banks and the
 * controller. The controller's role flag picks which bank is the draw pile.
 */
`timescale 1ns/1ps

module uno_deck import uno_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic       i_insert,
    input  card_t      i_prev_card,
    input  logic [2:0] i_draw,
    output logic       o_done,
    output logic       o_drawn,
    output card_t      o_card,
    output idx_t       o_left
);

    idx_t  rand_idx;
    idx_t  cursor;
    idx_t  count_0;
    idx_t  count_1;
    card_t top_card_0;
    card_t top_card_1;
    card_t held_card;
    logic  draw_sel;
    logic  done;
    logic  start_ok;
    logic  load_full_0;
    logic  clear_0;
    logic  swap_0;
    logic  push_0;
    logic  push_mix_0;
    logic  pop_0;
    logic  load_full_1;
    logic  clear_1;
    logic  swap_1;
    logic  push_1;
    logic  push_mix_1;
    logic  pop_1;

    assign start_ok = i_start & done;          // reseed only on an accepted start

    // played card is only valid with the insert pulse
    always_ff @(posedge i_clk) begin
        if (i_insert && done) held_card <= i_prev_card;
    end

    card_lfsr card_lfsr_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (start_ok),
        .o_rand_idx (rand_idx)
    );

    card_bank bank_0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_load_full (load_full_0),
        .i_clear     (clear_0),
        .i_swap      (swap_0),
        .i_push      (push_0),
        .i_push_mix  (push_mix_0),
        .i_pop       (pop_0),
        .i_cursor    (cursor),
        .i_rand_idx  (rand_idx),
        .i_card      (held_card),
        .o_top_card  (top_card_0),
        .o_count     (count_0)
    );

    card_bank bank_1 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_load_full (load_full_1),
        .i_clear     (clear_1),
        .i_swap      (swap_1),
        .i_push      (push_1),
        .i_push_mix  (push_mix_1),
        .i_pop       (pop_1),
        .i_cursor    (cursor),
        .i_rand_idx  (rand_idx),
        .i_card      (held_card),
        .o_top_card  (top_card_1),
        .o_count     (count_1)
    );

    deck_ctrl deck_ctrl_inst (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_insert      (i_insert),
        .i_draw        (i_draw),
        .i_rand_idx    (rand_idx),
        .i_count_0     (count_0),
        .i_count_1     (count_1),
        .o_load_full_0 (load_full_0),
        .o_clear_0     (clear_0),
        .o_swap_0      (swap_0),
        .o_push_0      (push_0),
        .o_push_mix_0  (push_mix_0),
        .o_pop_0       (pop_0),
        .o_load_full_1 (load_full_1),
        .o_clear_1     (clear_1),
        .o_swap_1      (swap_1),
        .o_push_1      (push_1),
        .o_push_mix_1  (push_mix_1),
        .o_pop_1       (pop_1),
        .o_cursor      (cursor),
        .o_draw_sel    (draw_sel),
        .o_done        (done),
        .o_drawn       (o_drawn)
    );

    assign o_done = done;
    assign o_card = draw_sel ? top_card_1 : top_card_0;   // draw pile top
    assign o_left = draw_sel ? count_1 : count_0;

endmodule

// ==== tb_uno_deck.sv ====
/*
 * tb_uno_deck
 * directed testbench for the card deck: ordered draw, draw codes, shuffle,
 * discard recycling and the both-piles-empty case
 */
`timescale 1ns/1ps

module tb_uno_deck
    import uno_pkg::*;
();

    logic        clk = 1'b0;     // starts low so time 0 gives no edge
    logic        rst_n;
    logic        start;
    logic        insert;
    card_t       prev_card;
    logic [2:0]  draw;
    logic        done;
    logic        drawn;
    card_t       card;
    idx_t        left;

    int          checks;
    int          errors;
    logic [31:0] rng_state;
    card_t       ordered [$];        // reference deck built from the card rules
    card_t       got_cards [$];      // cards seen on o_drawn pulses
    idx_t        left_at_pulse [$];

    uno_deck uno_deck_inst (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_start     (start),
        .i_insert    (insert),
        .i_prev_card (prev_card),
        .i_draw      (draw),
        .o_done      (done),
        .o_drawn     (drawn),
        .o_card      (card),
        .o_left      (left)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // per colour: one 0, pairs of 1..9 and the three actions, then both wilds
    task automatic build_deck();
        for (int c = 0; c < 4; c++) begin
            ordered.push_back({2'(c), 4'd0});
            for (int v = 1; v <= 12; v++) begin
                ordered.push_back({2'(c), 4'(v)});
                ordered.push_back({2'(c), 4'(v)});
            end
            ordered.push_back({2'(c), 4'd13});
            ordered.push_back({2'(c), 4'd14});
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) report_failure("timed out waiting for o_done to rise");
    endtask

    task automatic apply_reset();
        rst_n     = 1'b0;
        start     = 1'b0;
        insert    = 1'b0;
        prev_card = '0;
        draw      = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        wait_done(20);
    endtask

    // one draw request, collecting every card that pulses out
    task automatic draw_request(input logic [2:0] code, input int limit);
        int cycles;
        draw = code;
        @(negedge clk);
        draw   = '0;
        cycles = 0;
        while (!done && cycles < limit) begin
            if (drawn) begin
                got_cards.push_back(card);
                left_at_pulse.push_back(left);
            end
            @(negedge clk);
            cycles++;
        end
        if (!done) report_failure("timed out waiting for a draw request to finish");
    endtask

    task automatic insert_card(input card_t c, input int limit);
        insert    = 1'b1;
        prev_card = c;
        @(negedge clk);
        insert = 1'b0;
        wait_done(limit);
    endtask

    task automatic compare_multiset(input card_t want [$]);
        int want_tally [64];
        int got_tally [64];
        for (int v = 0; v < 64; v++) begin
            want_tally[v] = 0;
            got_tally[v]  = 0;
        end
        foreach (want[i]) want_tally[want[i]]++;
        foreach (got_cards[i]) got_tally[got_cards[i]]++;
        for (int v = 0; v < 64; v++) begin
            check_value($sformatf("o_card count of card 0x%0h", v), got_tally[v], want_tally[v]);
        end
    endtask

    task automatic test_ordered_draw();
        apply_reset();
        check_value("o_done", done, 1);
        check_value("o_left", left, DECK_SIZE);
        got_cards.delete();
        left_at_pulse.delete();
        for (int i = 0; i < DECK_SIZE; i++) draw_request(DRAW_ONE, 20);
        check_value("o_drawn pulses", got_cards.size(), DECK_SIZE);
        foreach (got_cards[i]) begin
            check_value("o_card", got_cards[i], ordered[DECK_SIZE - 1 - i]);  // top first
            check_value("o_left", left_at_pulse[i], DECK_SIZE - i);
        end
        check_value("o_left", left, 0);
    endtask

    task automatic test_draw_codes();
        logic [2:0] codes [3];
        int         sizes [3];
        int         remaining;
        codes[0]  = DRAW_ONE;
        codes[1]  = DRAW_TWO;
        codes[2]  = DRAW_FOUR;
        sizes[0]  = 1;
        sizes[1]  = 2;
        sizes[2]  = 4;
        remaining = DECK_SIZE;
        apply_reset();
        for (int k = 0; k < 3; k++) begin
            got_cards.delete();
            draw_request(codes[k], 40);
            check_value("o_drawn pulses", got_cards.size(), sizes[k]);
            foreach (got_cards[i]) begin
                check_value("o_card", got_cards[i], ordered[remaining - 1 - i]);
            end
            remaining -= sizes[k];
            check_value("o_left", left, remaining);
        end
    endtask

    task automatic test_shuffle();
        int moved;
        moved = 0;
        apply_reset();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done(20000);                                  // retries make this vary
        check_value("o_left", left, DECK_SIZE);
        got_cards.delete();
        for (int i = 0; i < DECK_SIZE / 4; i++) draw_request(DRAW_FOUR, 40);
        check_value("o_drawn pulses", got_cards.size(), DECK_SIZE);
        compare_multiset(ordered);
        foreach (got_cards[i]) begin
            if (got_cards[i] !== ordered[DECK_SIZE - 1 - i]) moved++;
        end
        if (moved == 0) report_failure("shuffled deck came out in the ordered sequence");
    endtask

    task automatic test_recycle();
        card_t c;
        card_t inserted [$];
        apply_reset();
        for (int i = 0; i < 25; i++) begin
            rng_state = xorshift(rng_state);
            c = {rng_state[9:8], 4'(rng_state[7:0] % 8'd15)};
            inserted.push_back(c);
            insert_card(c, 400);                           // mixing waits on the lfsr
            check_value("o_left", left, DECK_SIZE);
        end
        got_cards.delete();
        for (int i = 0; i < DECK_SIZE / 4; i++) draw_request(DRAW_FOUR, 40);
        check_value("o_drawn pulses", got_cards.size(), DECK_SIZE);
        check_value("o_left", left, 25);                   // piles swapped roles
        got_cards.delete();
        draw_request(DRAW_ONE, 20);
        check_value("o_left", left, 24);
        for (int i = 0; i < 6; i++) draw_request(DRAW_FOUR, 40);
        check_value("o_drawn pulses", got_cards.size(), 25);
        compare_multiset(inserted);
        check_value("o_left", left, 0);
    endtask

    task automatic test_empty_deck();
        apply_reset();
        for (int i = 0; i < DECK_SIZE / 4; i++) draw_request(DRAW_FOUR, 40);
        check_value("o_left", left, 0);
        got_cards.delete();
        draw_request(DRAW_FOUR, 40);                       // both piles empty
        check_value("o_drawn pulses", got_cards.size(), 0);
        check_value("o_done", done, 1);
    endtask

    initial begin
        checks    = 0;
        errors    = 0;
        rng_state = 32'h1db0_884e;
        rst_n     = 1'b0;
        start     = 1'b0;
        insert    = 1'b0;
        prev_card = '0;
        draw      = '0;
        build_deck();
        test_ordered_draw();
        test_draw_codes();
        test_shuffle();
        test_recycle();
        test_empty_deck();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
uno_pkg.sv
card_lfsr.sv
card_bank.sv
deck_ctrl.sv
uno_deck.sv
tb_uno_deck.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_uno_deck
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
